//--- Makefile
TOP := tb_motor_driver

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qFx "Simulation passed"

clean:
	rm -rf obj_dir

//--- design/driver_setup_seq.sv
`timescale 1ns/1ps

module driver_setup_seq (
  input  logic                                     clk_in,
  input  logic                                     reset_n_in,
  input  logic                                     busy,
  input  logic                                     done,
  input  motor_driver_pkg::frame_t                 rx_frame,
  output logic                                     send,
  output motor_driver_pkg::frame_t                 tx_frame,
  output logic                                     config_done,
  output logic [motor_driver_pkg::STATUS_BITS-1:0] status
);
  import motor_driver_pkg::*;

  // index into the setup list
  localparam int IDX_W = $clog2(NUM_CFG_WORDS);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_CFG_WORDS - 1);

  // issue a frame, wait for its reply, then hold forever
  typedef enum logic [1:0] {
    s_issue,
    s_wait,
    s_finish
  } seq_state_t;

  seq_state_t       state;
  logic [IDX_W-1:0] word_idx;

  // current setup word straight from the list
  // master samples it together with the send strobe
  assign tx_frame = CFG_WORDS[word_idx];

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state       <= s_issue;
      word_idx    <= '0;
      send        <= 1'b0;
      config_done <= 1'b0;
      status      <= '0;
    end else begin
      // send is a one cycle strobe
      send <= 1'b0;
      case (state)
        s_issue: begin
          // busy stays high through the master's cs_n high guard
          // so this waits out the gap between frames
          if (!busy) begin
            send  <= 1'b1;
            state <= s_wait;
          end
        end
        s_wait: begin
          if (done) begin
            // chip status rides in the top byte of every reply
            status <= rx_frame[FRAME_BITS-1 -: STATUS_BITS];
            if (word_idx == IDX_LAST) begin
              config_done <= 1'b1;
              state       <= s_finish;
            end else begin
              word_idx <= word_idx + 1'b1;
              state    <= s_issue;
            end
          end
        end
        s_finish: begin
          // setup complete until the next reset
          state <= s_finish;
        end
        default: state <= s_issue;
      endcase
    end
  end

endmodule

//--- design/motor_driver.sv
`timescale 1ns/1ps

module motor_driver #(
  parameter int SPI_HALF_PERIOD = 4,
  parameter int SPEED_WIDTH = 32
) (
  input  logic                                     clk_in,
  input  logic                                     reset_n_in,
  input  logic                                     miso,
  input  logic                                     step_enable,
  input  logic [SPEED_WIDTH-1:0]                   speed,
  output logic                                     sclk,
  output logic                                     mosi,
  output logic                                     cs_n,
  output logic                                     step_out,
  output logic                                     config_done,
  output logic [motor_driver_pkg::STATUS_BITS-1:0] status
);
  import motor_driver_pkg::*;

  // sequencer to spi master
  logic   send;
  logic   busy;
  logic   done;
  frame_t tx_frame;
  frame_t rx_frame;

  // walks the setup list after reset
  driver_setup_seq u_setup_seq (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .busy        (busy),
    .done        (done),
    .rx_frame    (rx_frame),
    .send        (send),
    .tx_frame    (tx_frame),
    .config_done (config_done),
    .status      (status)
  );

  // spi mode 3 frame engine toward the driver chip
  spi_frame_master #(
    .SPI_HALF_PERIOD (SPI_HALF_PERIOD)
  ) u_spi_master (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .send       (send),
    .tx_frame   (tx_frame),
    .miso       (miso),
    .sclk       (sclk),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .busy       (busy),
    .done       (done),
    .rx_frame   (rx_frame)
  );

  // step pin, held low until setup completes
  step_pulse_gen #(
    .SPEED_WIDTH (SPEED_WIDTH)
  ) u_step_gen (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .speed       (speed),
    .step_enable (step_enable),
    .config_done (config_done),
    .step_out    (step_out)
  );

endmodule

//--- design/motor_driver_pkg.sv
package motor_driver_pkg;

  // spi frame layout, address byte then 32 data bits
  localparam int FRAME_BITS = 40;
  // status byte returned in the top bits of each reply
  localparam int STATUS_BITS = 8;
  // length of the setup list
  localparam int NUM_CFG_WORDS = 5;

  // one spi frame, msb first on the wire
  typedef logic [FRAME_BITS-1:0] frame_t;

  // write access flag in the address byte
  localparam logic [7:0] WRITE_BIT = 8'h80;

  // driver chip register addresses
  localparam logic [7:0] ADDR_GCONF = 8'h00;
  localparam logic [7:0] ADDR_IHOLD_IRUN = 8'h10;
  localparam logic [7:0] ADDR_TPOWERDOWN = 8'h11;
  localparam logic [7:0] ADDR_TPWMTHRS = 8'h13;
  localparam logic [7:0] ADDR_CHOPCONF = 8'h6C;

  // setup list, sent in index order after reset
  localparam frame_t CFG_WORDS [NUM_CFG_WORDS] = '{
    // toff 3, hstrt 4, hend 1, tbl 2, chm 0 for spreadCycle
    {WRITE_BIT | ADDR_CHOPCONF, 32'h0001_00C3},
    // ihold 10, irun 31, iholddelay 6
    {WRITE_BIT | ADDR_IHOLD_IRUN, 32'h0006_1F0A},
    // standstill delay before power down
    {WRITE_BIT | ADDR_TPOWERDOWN, 32'h0000_000A},
    // en_pwm_mode set, stealthChop with default pwm settings
    {WRITE_BIT | ADDR_GCONF, 32'h0000_0004},
    // stealthChop upper velocity threshold, 500
    {WRITE_BIT | ADDR_TPWMTHRS, 32'h0000_01F4}
  };

endpackage

//--- design/spi_frame_master.sv
`timescale 1ns/1ps

module spi_frame_master #(
  parameter int SPI_HALF_PERIOD = 4
) (
  input  logic                     clk_in,
  input  logic                     reset_n_in,
  input  logic                     send,
  input  motor_driver_pkg::frame_t tx_frame,
  input  logic                     miso,
  output logic                     sclk,
  output logic                     mosi,
  output logic                     cs_n,
  output logic                     busy,
  output logic                     done,
  output motor_driver_pkg::frame_t rx_frame
);
  import motor_driver_pkg::*;

  // half period counter and bit counter widths
  localparam int HCNT_W = $clog2(SPI_HALF_PERIOD);
  localparam int BCNT_W = $clog2(FRAME_BITS);
  localparam logic [HCNT_W-1:0] HCNT_LAST = HCNT_W'(SPI_HALF_PERIOD - 1);
  localparam logic [BCNT_W-1:0] BCNT_LAST = BCNT_W'(FRAME_BITS - 1);

  // idle, shifting bits, trailing cs_n and guard window
  typedef enum logic [1:0] {
    s_idle,
    s_shift,
    s_trail
  } spi_state_t;

  spi_state_t        state;
  logic [HCNT_W-1:0] hcnt;
  logic [BCNT_W-1:0] bcnt;
  frame_t            shreg;
  logic              half_tick;

  // end of the current half period
  assign half_tick = (hcnt == HCNT_LAST);
  // busy also covers the cs_n high guard after done
  assign busy = (state != s_idle);
  // received bits sit in the shared shift register
  assign rx_frame = shreg;

  // bus timing and frame control
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state <= s_idle;
      hcnt  <= '0;
      bcnt  <= '0;
      sclk  <= 1'b1;
      mosi  <= 1'b0;
      cs_n  <= 1'b1;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        s_idle: begin
          if (send) begin
            cs_n  <= 1'b0;
            // first falling edge one cycle after cs_n drops
            hcnt  <= HCNT_LAST;
            bcnt  <= '0;
            state <= s_shift;
          end
        end
        s_shift: begin
          if (half_tick) begin
            hcnt <= '0;
            sclk <= ~sclk;
            if (sclk) begin
              // falling edge, present next bit msb first
              mosi <= shreg[FRAME_BITS-1];
            end else if (bcnt == BCNT_LAST) begin
              // last rising edge done
              state <= s_trail;
            end else begin
              bcnt <= bcnt + 1'b1;
            end
          end else begin
            hcnt <= hcnt + 1'b1;
          end
        end
        s_trail: begin
          if (half_tick) begin
            if (!cs_n) begin
              // half period after the last rising edge
              cs_n <= 1'b1;
              done <= 1'b1;
              // guard lasts one cycle less, so the next send lands a half period later
              hcnt <= HCNT_W'(1);
            end else begin
              state <= s_idle;
              mosi  <= 1'b0;
              hcnt  <= '0;
            end
          end else begin
            hcnt <= hcnt + 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // shift register, loads tx_frame on send
  // miso enters at the lsb on each rising edge
  always_ff @(posedge clk_in) begin
    if (state == s_idle && send) begin
      shreg <= tx_frame;
    end else if (state == s_shift && half_tick && !sclk) begin
      shreg <= {shreg[FRAME_BITS-2:0], miso};
    end
  end

endmodule

//--- design/step_pulse_gen.sv
`timescale 1ns/1ps

module step_pulse_gen #(
  parameter int SPEED_WIDTH = 32
) (
  input  logic                   clk_in,
  input  logic                   reset_n_in,
  input  logic [SPEED_WIDTH-1:0] speed,
  input  logic                   step_enable,
  input  logic                   config_done,
  output logic                   step_out
);

  logic [SPEED_WIDTH-1:0] cnt;
  logic [SPEED_WIDTH-1:0] speed_q;
  logic                   active;
  logic                   toggle;

  // steps only once the chip is configured
  assign active = step_enable & config_done;
  // half step period reached
  assign toggle = (cnt == speed_q);

  // divider counter and step level
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      cnt      <= '0;
      step_out <= 1'b0;
    end else if (!active) begin
      cnt      <= '0;
      step_out <= 1'b0;
    end else if (toggle) begin
      cnt      <= '0;
      step_out <= ~step_out;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // speed captured at each toggle
  // tracks the input while stopped so the first period uses it
  always_ff @(posedge clk_in) begin
    if (!active || toggle) begin
      speed_q <= speed;
    end
  end

endmodule

//--- sim/motor_driver_asserts.sv
`timescale 1ns/1ps

module motor_driver_asserts (
  input logic clk_in,
  input logic reset_n_in,
  input logic sclk,
  input logic cs_n,
  input logic send,
  input logic busy,
  input logic done,
  input logic step_enable,
  input logic config_done,
  input logic step_out
);

  // mode 3 idle level
  a_sclk_idle: assert property (@(posedge clk_in) disable iff (!reset_n_in) cs_n |-> sclk)
    else $error("sclk low while cs_n high");

  // no back-pressure on the frame strobe
  a_send_idle: assert property (@(posedge clk_in) disable iff (!reset_n_in) send |-> !busy)
    else $error("send while spi master busy");

  a_done_pulse: assert property (@(posedge clk_in) disable iff (!reset_n_in) done |=> !done)
    else $error("done wider than one cycle");

  // gating reaches the pin one cycle later
  a_step_gate: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (!step_enable || !config_done) |=> !step_out)
    else $error("step_out high while gated");

endmodule

bind motor_driver motor_driver_asserts u_asserts (
  .clk_in      (clk_in),
  .reset_n_in  (reset_n_in),
  .sclk        (sclk),
  .cs_n        (cs_n),
  .send        (send),
  .busy        (busy),
  .done        (done),
  .step_enable (step_enable),
  .config_done (config_done),
  .step_out    (step_out)
);

//--- sim/motor_driver_tests.txt
# C expected_frame reply_word in hex
# S speed enable cycles in decimal
# E marks the end of the list
C ec000100c3 08a5a5a5a5
C 9000061f0a 0b12345678
C 910000000a 4000000001
C 8000000004 81deadbeef
C 93000001f4 c30f0f0f0f
S 3 1 60
S 0 1 30
S 0 0 20
S 0 1 20
S 7 1 80
S 12 0 25
S 12 1 100
S 1 1 30
E

//--- sim/tb_motor_driver.sv
`timescale 1ns/1ps

module tb_motor_driver;

  localparam int SPI_HALF_PERIOD = 4;
  localparam int SPEED_WIDTH = 32;
  localparam int NUM_FRAMES = 5;
  localparam int FRAME_LEN = 40;
  // longest random idle gap before a step segment
  localparam int MAX_GAP = 8;

  logic                   clk_in;
  logic                   reset_n_in;
  logic                   miso;
  logic                   step_enable;
  logic [SPEED_WIDTH-1:0] speed;
  logic                   sclk;
  logic                   mosi;
  logic                   cs_n;
  logic                   step_out;
  logic                   config_done;
  logic [7:0]             status;

  // vectors loaded from the data file
  logic [39:0] exp_frames[$];
  logic [39:0] replies[$];
  int          seg_speed[$];
  int          seg_enable[$];
  int          seg_len[$];
  int          limit_cycles;

  motor_driver #(
    .SPI_HALF_PERIOD (SPI_HALF_PERIOD),
    .SPEED_WIDTH     (SPEED_WIDTH)
  ) UUT (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .miso        (miso),
    .step_enable (step_enable),
    .speed       (speed),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .step_out    (step_out),
    .config_done (config_done),
    .status      (status)
  );

  // 10 ns clock
  always #5 clk_in = ~clk_in;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "value check failed");
    end
  endtask

  // step pin must stay quiet until setup ends
  task automatic check_step_gated();
    if (!config_done) begin
      check_value("step_out", 64'(0), 64'(step_out));
    end
  endtask

  task automatic read_tests();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [39:0]      frame;
    logic [39:0]      reply;
    int               spd;
    int               en;
    int               len;
    logic [8*160-1:0] rest;
    bit               ended;
    ended = 1'b0;
    fd = $fopen("sim/motor_driver_tests.txt", "r");
    if (fd == 0) report_failure("cannot open sim/motor_driver_tests.txt");
    while (!ended) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        report_failure("test file ends without an E line");
      end else if (tag == "#") begin
        // rest of a comment line
        code = $fgets(rest, fd);
      end else if (tag == "C") begin
        code = $fscanf(fd, "%h %h", frame, reply);
        if (code != 2) report_failure("malformed C line in test file");
        exp_frames.push_back(frame);
        replies.push_back(reply);
      end else if (tag == "S") begin
        code = $fscanf(fd, "%d %d %d", spd, en, len);
        if (code != 3) report_failure("malformed S line in test file");
        seg_speed.push_back(spd);
        seg_enable.push_back(en);
        seg_len.push_back(len);
      end else if (tag == "E") begin
        ended = 1'b1;
      end else begin
        report_failure("unknown line type in test file");
      end
    end
    $fclose(fd);
    if (exp_frames.size() != NUM_FRAMES) report_failure("test file does not hold 5 C lines");
    // setup frames plus slack, then every segment with its worst gap, doubled
    limit_cycles = NUM_FRAMES * (FRAME_LEN * 2 * SPI_HALF_PERIOD + 20);
    foreach (seg_len[i]) limit_cycles += seg_len[i] + MAX_GAP;
    limit_cycles = limit_cycles * 2;
  endtask

  // chip side of one frame, mode 3
  task automatic serve_frame(input int idx);
    logic [39:0] captured;
    logic [39:0] reply;
    int          rx_bits;
    logic        prev_sclk;
    captured = '0;
    reply = replies[idx];
    rx_bits = 0;
    while (cs_n) begin
      @(negedge clk_in);
      check_step_gated();
    end
    prev_sclk = sclk;
    while (!cs_n) begin
      @(negedge clk_in);
      check_step_gated();
      if (prev_sclk && !sclk) begin
        // falling sclk, next reply bit msb first
        miso = reply[39];
        reply = reply << 1;
      end else if (!prev_sclk && sclk) begin
        captured = {captured[38:0], mosi};
        rx_bits++;
      end
      prev_sclk = sclk;
    end
    check_value("frame bits", 64'(FRAME_LEN), 64'(rx_bits));
    check_value("mosi frame", 64'(exp_frames[idx]), 64'(captured));
    // status lands one cycle after done
    @(negedge clk_in);
    check_value("status", 64'(replies[idx][39:32]), 64'(status));
    check_value("config_done", 64'(idx == NUM_FRAMES - 1), 64'(config_done));
    check_step_gated();
  endtask

  task automatic run_segment(input int idx);
    int   last_rise;
    int   rises;
    int   cyc;
    logic prev_step;
    speed = SPEED_WIDTH'(seg_speed[idx]);
    step_enable = (seg_enable[idx] != 0);
    last_rise = -1;
    rises = 0;
    prev_step = step_out;
    for (cyc = 0; cyc < seg_len[idx]; cyc++) begin
      @(negedge clk_in);
      if (seg_enable[idx] == 0) begin
        check_value("step_out", 64'(0), 64'(step_out));
      end else if (step_out && !prev_step) begin
        // first rising edge only opens the measurement
        if (last_rise >= 0) begin
          check_value("step period", 64'(2 * (seg_speed[idx] + 1)), 64'(cyc - last_rise));
        end
        last_rise = cyc;
        rises++;
      end
      prev_step = step_out;
    end
    if (seg_enable[idx] != 0 && rises < 2) begin
      report_failure("enabled segment produced fewer than two step pulses");
    end
  endtask

  initial begin
    int idx;
    clk_in = 1'b0;
    reset_n_in = 1'b0;
    miso = 1'b0;
    // enabled from reset on, gated by config_done
    step_enable = 1'b1;
    speed = SPEED_WIDTH'(5);
    void'($urandom(97652));
    read_tests();
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    reset_n_in = 1'b1;
    for (idx = 0; idx < NUM_FRAMES; idx++) begin
      serve_frame(idx);
    end
    for (idx = 0; idx < seg_len.size(); idx++) begin
      repeat ($urandom % MAX_GAP) @(negedge clk_in);
      run_segment(idx);
    end
    $display("Simulation passed");
    $finish;
  end

  // watchdog, armed once the test file is loaded
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_in);
    $display("timeout after %0d cycles without finishing the tests", limit_cycles);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- tb.f
design/motor_driver_pkg.sv
design/spi_frame_master.sv
design/driver_setup_seq.sv
design/step_pulse_gen.sv
design/motor_driver.sv
sim/motor_driver_asserts.sv
sim/tb_motor_driver.sv
